// File: Makefile
VERILATOR ?= verilator
TOP ?= fetchFrontTb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timing
PASS_TEXT ?= TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard sim/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: sim/fetchTable.svh
// Stimulus rows; expected decOut belongs to the word applied one row earlier
// Column order is group, {gena oena branchTaken msrIe intReq}, instData, class, rd, ra, simm,
// stall and check

// Test words in MicroBlaze type A/B layout
localparam logic [31:0] AddiNeg  = {6'o10, 5'd3, 5'd4, 16'hFFF0};
localparam logic [31:0] AddReg   = {6'o00, 5'd5, 5'd6, 16'h3800};
localparam logic [31:0] AddiMin  = {6'o10, 5'd7, 5'd8, 16'h8001};
localparam logic [31:0] AddiPos  = {6'o10, 5'd9, 5'd1, 16'h0123};
localparam logic [31:0] AddiJoin = {6'o10, 5'd10, 5'd11, 16'h1234};
localparam logic [31:0] BraWord  = {6'o56, 5'd0, 5'd0, 16'h0200};
localparam logic [31:0] ImmWord  = {6'o54, 5'd0, 5'd0, 16'hABCD};
localparam logic [31:0] MulWord  = {6'o20, 5'd12, 5'd13, 16'h7000};
localparam logic [31:0] LwWord   = {6'o62, 5'd15, 5'd16, 16'h8800};
localparam logic [31:0] SwWord   = {6'o66, 5'd17, 5'd18, 16'h0004};

localparam int TableLen = 41;

tableRow tableRows [TableLen] = '{
   // First row sees the reset value of decOut
   '{3'd1, 5'b11000, AddiNeg, fetchPkg::opAlu, 5'd0, 5'd0, 32'h00000000, 1'b0, 1'b1},
   '{3'd1, 5'b11000, AddReg, fetchPkg::opAlu, 5'd3, 5'd4, 32'hFFFFFFF0, 1'b0, 1'b1},
   '{3'd1, 5'b11000, AddiMin, fetchPkg::opAlu, 5'd5, 5'd6, 32'h00003800, 1'b0, 1'b1},
   '{3'd1, 5'b11000, AddiPos, fetchPkg::opAlu, 5'd7, 5'd8, 32'hFFFF8001, 1'b0, 1'b1},
   // Delay slot word swapped for the filler
   '{3'd2, 5'b11000, BraWord, fetchPkg::opAlu, 5'd9, 5'd1, 32'h00000123, 1'b0, 1'b1},
   '{3'd2, 5'b11100, AddiNeg, fetchPkg::opBranch, 5'd0, 5'd0, 32'h00000200, 1'b0, 1'b1},
   '{3'd2, 5'b11000, AddReg, fetchPkg::opNop, 5'd0, 5'd0, 32'h00000000, 1'b0, 1'b1},
   '{3'd2, 5'b11000, AddiMin, fetchPkg::opAlu, 5'd5, 5'd6, 32'h00003800, 1'b0, 1'b1},
   // Prefix high half joined to the next low half
   '{3'd3, 5'b11000, ImmWord, fetchPkg::opAlu, 5'd7, 5'd8, 32'hFFFF8001, 1'b0, 1'b1},
   '{3'd3, 5'b11000, AddiJoin, fetchPkg::opImmPrefix, 5'd0, 5'd0, 32'hFFFFABCD, 1'b0, 1'b1},
   '{3'd3, 5'b11000, AddiPos, fetchPkg::opAlu, 5'd10, 5'd11, 32'hABCD1234, 1'b0, 1'b1},
   '{3'd3, 5'b11000, AddiNeg, fetchPkg::opAlu, 5'd9, 5'd1, 32'h00000123, 1'b0, 1'b1},
   // Request pulse so the vector replaces the third word
   '{3'd4, 5'b11011, AddReg, fetchPkg::opAlu, 5'd3, 5'd4, 32'hFFFFFFF0, 1'b0, 1'b1},
   '{3'd4, 5'b11010, AddiMin, fetchPkg::opAlu, 5'd5, 5'd6, 32'h00003800, 1'b0, 1'b1},
   '{3'd4, 5'b11010, AddiPos, fetchPkg::opAlu, 5'd7, 5'd8, 32'hFFFF8001, 1'b0, 1'b1},
   '{3'd4, 5'b11000, AddiNeg, fetchPkg::opBranch, 5'd14, 5'd14, 32'h00000010, 1'b0, 1'b1},
   '{3'd4, 5'b11000, AddReg, fetchPkg::opAlu, 5'd3, 5'd4, 32'hFFFFFFF0, 1'b0, 1'b1},
   // Flag lands behind a prefix and the vector waits one word
   '{3'd4, 5'b11011, AddiMin, fetchPkg::opAlu, 5'd5, 5'd6, 32'h00003800, 1'b0, 1'b1},
   '{3'd4, 5'b11010, ImmWord, fetchPkg::opAlu, 5'd7, 5'd8, 32'hFFFF8001, 1'b0, 1'b1},
   '{3'd4, 5'b11010, AddiJoin, fetchPkg::opImmPrefix, 5'd0, 5'd0, 32'hFFFFABCD, 1'b0, 1'b1},
   '{3'd4, 5'b11010, AddiPos, fetchPkg::opAlu, 5'd10, 5'd11, 32'hABCD1234, 1'b0, 1'b1},
   '{3'd4, 5'b11000, AddiNeg, fetchPkg::opBranch, 5'd14, 5'd14, 32'h00000010, 1'b0, 1'b1},
   '{3'd4, 5'b11000, AddReg, fetchPkg::opAlu, 5'd3, 5'd4, 32'hFFFFFFF0, 1'b0, 1'b1},
   // msrIe low so the request is ignored
   '{3'd4, 5'b11001, AddiMin, fetchPkg::opAlu, 5'd5, 5'd6, 32'h00003800, 1'b0, 1'b1},
   '{3'd4, 5'b11001, AddiPos, fetchPkg::opAlu, 5'd7, 5'd8, 32'hFFFF8001, 1'b0, 1'b1},
   '{3'd4, 5'b11001, AddiNeg, fetchPkg::opAlu, 5'd9, 5'd1, 32'h00000123, 1'b0, 1'b1},
   '{3'd4, 5'b11000, AddReg, fetchPkg::opAlu, 5'd3, 5'd4, 32'hFFFFFFF0, 1'b0, 1'b1},
   // gena dropped while stall is up
   '{3'd5, 5'b10000, MulWord, fetchPkg::opAlu, 5'd5, 5'd6, 32'h00003800, 1'b1, 1'b1},
   '{3'd5, 5'b00000, MulWord, fetchPkg::opAlu, 5'd5, 5'd6, 32'h00003800, 1'b0, 1'b1},
   '{3'd5, 5'b11000, AddiNeg, fetchPkg::opMul, 5'd12, 5'd13, 32'h00007000, 1'b0, 1'b1},
   '{3'd5, 5'b10000, LwWord, fetchPkg::opAlu, 5'd3, 5'd4, 32'hFFFFFFF0, 1'b1, 1'b1},
   '{3'd5, 5'b00000, LwWord, fetchPkg::opAlu, 5'd3, 5'd4, 32'hFFFFFFF0, 1'b0, 1'b1},
   '{3'd5, 5'b10000, SwWord, fetchPkg::opLoad, 5'd15, 5'd16, 32'hFFFF8800, 1'b1, 1'b1},
   '{3'd5, 5'b01000, SwWord, fetchPkg::opLoad, 5'd15, 5'd16, 32'hFFFF8800, 1'b0, 1'b1},
   '{3'd5, 5'b11000, MulWord, fetchPkg::opStore, 5'd17, 5'd18, 32'h00000004, 1'b0, 1'b1},
   '{3'd5, 5'b11000, AddReg, fetchPkg::opMul, 5'd12, 5'd13, 32'h00007000, 1'b0, 1'b1},
   // Frozen pipeline where changing data must not leak through
   '{3'd6, 5'b01000, AddiMin, fetchPkg::opMul, 5'd12, 5'd13, 32'h00007000, 1'b0, 1'b1},
   '{3'd6, 5'b01000, AddiPos, fetchPkg::opMul, 5'd12, 5'd13, 32'h00007000, 1'b0, 1'b1},
   '{3'd6, 5'b01000, AddiJoin, fetchPkg::opMul, 5'd12, 5'd13, 32'h00007000, 1'b0, 1'b1},
   '{3'd6, 5'b11000, AddiNeg, fetchPkg::opAlu, 5'd5, 5'd6, 32'h00003800, 1'b0, 1'b1},
   '{3'd6, 5'b11000, AddiMin, fetchPkg::opAlu, 5'd3, 5'd4, 32'hFFFFFFF0, 1'b0, 1'b1}
};

// File: sim/fetchFrontTb.sv
// Testbench for the fetch front end; instData comes from the table rows, not from a memory at instAddr
`timescale 1ns/1ps

module fetchFrontTb;

   localparam int ClkPeriod = 8;
   localparam int ResetCycles = 5;
   localparam logic [31:0] BranchTarget = 32'h0000_0200;

   // One table row with ctl holding {gena, oena, branchTaken, msrIe, intReq}
   typedef struct packed {
      logic [2:0]       grp;
      logic [4:0]       ctl;
      logic [31:0]      data;
      fetchPkg::opClass cls;
      logic [4:0]       rd;
      logic [4:0]       ra;
      logic [31:0]      simm;
      logic             stall;
      logic             chk;
   } tableRow;

   `include "fetchTable.svh"

   // Table plus margin for reset and drain
   localparam int WatchdogTime = (TableLen + 20) * ClkPeriod;

   logic                 gclk;
   logic                 grst;
   logic                 gena;
   logic                 oena;
   logic                 branchTaken;
   logic [31:0]          branchTarget;
   logic                 msrIe;
   logic                 intReq;
   logic [31:0]          instData;
   logic [31:0]          instAddr;
   logic                 instEnable;
   fetchPkg::decodedInst decOut;
   logic                 stall;

   tableRow     row;
   logic [31:0] expAddr;
   int          checkCount;
   int          failCount;
   int          groupChecks;
   int          groupFails;

   fetchFront #(
      .AddrWidth(32)
   ) dut_i (
      .gclk(gclk),
      .grst(grst),
      .gena(gena),
      .oena(oena),
      .branchTaken(branchTaken),
      .branchTarget(branchTarget),
      .msrIe(msrIe),
      .intReq(intReq),
      .instData(instData),
      .instAddr(instAddr),
      .instEnable(instEnable),
      .decOut(decOut),
      .stall(stall)
   );

   // Free-running clock
   initial begin
      gclk = 1'b0;
      forever #(ClkPeriod / 2) gclk = ~gclk;
   end

   function automatic string groupName(input logic [2:0] grp);
      case (grp)
         3'd1: return "straight-line alu";
         3'd2: return "taken branch";
         3'd3: return "immediate prefix";
         3'd4: return "interrupt";
         3'd5: return "stall";
         3'd6: return "hold";
         default: return "unknown";
      endcase
   endfunction

   // Compare counted per group and overall
   task automatic compareValue(input int idx, input string name,
                               input logic [31:0] expVal, input logic [31:0] actVal);
      checkCount++;
      groupChecks++;
      assert (actVal === expVal) else begin
         $display("** Error: row %0d %s expected %h actual %h", idx, name, expVal, actVal);
         failCount++;
         groupFails++;
      end
   endtask

   task automatic applyRow(input tableRow r);
      gena        = r.ctl[4];
      oena        = r.ctl[3];
      branchTaken = r.ctl[2];
      msrIe       = r.ctl[1];
      intReq      = r.ctl[0];
      instData    = r.data;
   endtask

   task automatic checkRow(input int idx, input tableRow r);
      compareValue(idx, "instAddr", expAddr, instAddr);
      compareValue(idx, "instEnable", 32'(r.ctl[4]), 32'(instEnable));
      // Decoded fields only where the row expects them
      if (r.chk) begin
         compareValue(idx, "decOut.cls", 32'(r.cls), 32'(decOut.cls));
         compareValue(idx, "decOut.rd", 32'(r.rd), 32'(decOut.rd));
         compareValue(idx, "decOut.ra", 32'(r.ra), 32'(decOut.ra));
         // Type A view of the low immediate half
         compareValue(idx, "decOut.rb", 32'(r.simm[15:11]), 32'(decOut.rb));
         compareValue(idx, "decOut.alt", 32'(r.simm[10:0]), 32'(decOut.alt));
         compareValue(idx, "decOut.simm", r.simm, decOut.simm);
         compareValue(idx, "stall", 32'(r.stall), 32'(stall));
      end
   endtask

   task automatic reportGroup(input logic [2:0] grp);
      $display("Group %s: %0d checks, %0d mismatches", groupName(grp), groupChecks, groupFails);
      groupChecks = 0;
      groupFails  = 0;
   endtask

   // Stimulus and checking
   initial begin
      grst         = 1'b1;
      gena         = 1'b0;
      oena         = 1'b1;
      branchTaken  = 1'b0;
      branchTarget = BranchTarget;
      msrIe        = 1'b0;
      intReq       = 1'b0;
      instData     = '0;
      expAddr      = '0;
      checkCount   = 0;
      failCount    = 0;
      groupChecks  = 0;
      groupFails   = 0;
      repeat (ResetCycles) @(posedge gclk);
      @(negedge gclk);
      grst = 1'b0;
      for (int i = 0; i < TableLen; i++) begin
         row = tableRows[i];
         applyRow(row);
         @(posedge gclk);
         // Target on a taken branch, else plus four, frozen without gena
         if (row.ctl[4]) begin
            expAddr = row.ctl[2] ? BranchTarget : expAddr + 32'd4;
         end
         #1;
         checkRow(i, row);
         if (i == TableLen - 1 || tableRows[i + 1].grp != row.grp) begin
            reportGroup(row.grp);
         end
         @(negedge gclk);
      end
      $display("Summary: %0d checks passed, %0d failed", checkCount - failCount, failCount);
      if (failCount == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WatchdogTime);
      $display("Run timed out after %0d ns before the table finished", WatchdogTime);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: verilog/fetchCounter.sv
// Program counter stepping by four on gena; AddrWidth must be at least 3 and the counter wraps
`timescale 1ns/1ps

module fetchCounter #(
   parameter int AddrWidth = 32
) (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 gena,
   input  logic                 branchTaken,
   input  logic [AddrWidth-1:0] branchTarget,
   output logic [AddrWidth-1:0] instAddr
);

   // Word step
   localparam logic [AddrWidth-1:0] AddrStep = AddrWidth'(4);

   logic [AddrWidth-1:0] seqAddr;
   logic [AddrWidth-1:0] nextAddr;

   // Sequential successor
   assign seqAddr = instAddr + AddrStep;

   // Taken branch wins over the sequential path
   always_comb begin
      if (branchTaken) begin
         nextAddr = branchTarget;
      end else begin
         nextAddr = seqAddr;
      end
   end

   // Address register
   // Holds while the pipeline is frozen
   always_ff @(posedge gclk) begin
      if (grst) begin
         instAddr <= '0;
      end else if (gena) begin
         instAddr <= nextAddr;
      end
   end

endmodule

// File: verilog/fetchFront.sv
// Fetch front end; instruction memory must answer combinationally and gena should drop on stall
`timescale 1ns/1ps

module fetchFront #(
   parameter int AddrWidth = 32
) (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 gena,
   input  logic                 oena,
   input  logic                 branchTaken,
   input  logic [AddrWidth-1:0] branchTarget,
   input  logic                 msrIe,
   input  logic                 intReq,
   input  logic [31:0]          instData,
   output logic [AddrWidth-1:0] instAddr,
   output logic                 instEnable,
   output fetchPkg::decodedInst decOut,
   output logic                 stall
);

   fetchPkg::instWord bufInst;
   logic [31:0]       bufSimm;

   // Memory read follows the pipeline advance
   assign instEnable = gena;

   fetchCounter #(
      .AddrWidth(AddrWidth)
   ) counter_i (
      .gclk(gclk),
      .grst(grst),
      .gena(gena),
      .branchTaken(branchTaken),
      .branchTarget(branchTarget),
      .instAddr(instAddr)
   );

   instBuffer buffer_i (
      .gclk(gclk),
      .grst(grst),
      .gena(gena),
      .oena(oena),
      .branchTaken(branchTaken),
      .msrIe(msrIe),
      .intReq(intReq),
      .instData(instData),
      .bufInst(bufInst),
      .bufSimm(bufSimm),
      .stall(stall)
   );

   instDecode decode_i (
      .gclk(gclk),
      .grst(grst),
      .gena(gena),
      .bufInst(bufInst),
      .bufSimm(bufSimm),
      .decOut(decOut)
   );

endmodule

// File: verilog/fetchPkg.sv
// Front-end types for 32-bit MicroBlaze-style words; every paired opcode differs only in bit 3
package fetchPkg;

   // Raw instruction word in type A/B field order
   typedef struct packed {
      logic [5:0]  opc;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [15:0] imm;
   } instWord;

   // Operation class handed to later stages
   typedef enum logic [3:0] {
      opAlu = 4'd0,
      opImmPrefix,
      opBranch,
      opCondBranch,
      opReturn,
      opMul,
      opShift,
      opLoad,
      opStore,
      opNop
   } opClass;

   // Decoder output with the immediate already joined or extended
   typedef struct packed {
      opClass      cls;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [10:0] alt;
      logic [31:0] simm;
   } decodedInst;

   localparam logic [5:0] opcImm = 6'o54;
   localparam logic [5:0] opcRtd = 6'o55;
   // Pair bases whose partners have bit 3 set
   localparam logic [5:0] opcBru = 6'o46;
   localparam logic [5:0] opcBcc = 6'o47;
   localparam logic [5:0] opcMul = 6'o20;
   localparam logic [5:0] opcBsf = 6'o21;
   localparam logic [5:0] opcPairMask = 6'o67;

   // Delay slot filler and interrupt jump to vector 0x10
   localparam logic [31:0] nopWord = 32'h8800_0000;
   localparam logic [31:0] intVector = 32'hB9CE_0010;

   // True for either member of an opcode pair
   function automatic logic opcPair(input logic [5:0] opc, input logic [5:0] base);
      return (opc & opcPairMask) == base;
   endfunction

endpackage

// File: verilog/instBuffer.sv
// Instruction buffer; the interrupt flag stays set until msrIe drops and stall is advisory only
`timescale 1ns/1ps

module instBuffer (
   input  logic             gclk,
   input  logic             grst,
   input  logic             gena,
   input  logic             oena,
   input  logic             branchTaken,
   input  logic             msrIe,
   input  logic             intReq,
   input  logic [31:0]      instData,
   output fetchPkg::instWord bufInst,
   output logic [31:0]      bufSimm,
   output logic             stall
);

   logic [1:0]        intDeb;
   logic              intFlag;
   logic              prevImm;
   logic              prevRtd;
   logic              prevBru;
   logic              prevBcc;
   logic              intAllowed;
   fetchPkg::instWord selWord;
   logic [31:0]       selSimm;
   logic              isMul;
   logic              isBsf;
   logic              isLoad;
   logic              isStore;
   logic              multiCycle;

   // Interrupt latch
   // Runs on every clock so a frozen pipeline still sees the request
   always_ff @(posedge gclk) begin
      if (grst) begin
         intDeb  <= 2'b00;
         intFlag <= 1'b0;
      end else begin
         if (msrIe) begin
            intDeb <= {intDeb[0], intReq};
         end
         // Sticky until interrupts are disabled
         intFlag <= (intFlag | intDeb[0] | intDeb[1]) & msrIe;
      end
   end

   // Previous word decode
   assign prevImm = (bufInst.opc == fetchPkg::opcImm);
   assign prevRtd = (bufInst.opc == fetchPkg::opcRtd);
   assign prevBru = fetchPkg::opcPair(bufInst.opc, fetchPkg::opcBru);
   assign prevBcc = fetchPkg::opcPair(bufInst.opc, fetchPkg::opcBcc);

   // Never split a prefix pair or land in a delay slot
   assign intAllowed = intFlag & !prevImm & !prevRtd & !prevBru & !prevBcc;

   // Word selection
   always_comb begin
      if (branchTaken) begin
         selWord = fetchPkg::instWord'(fetchPkg::nopWord);
      end else if (intAllowed) begin
         selWord = fetchPkg::instWord'(fetchPkg::intVector);
      end else begin
         selWord = fetchPkg::instWord'(instData);
      end
   end

   // Immediate join or sign extension
   always_comb begin
      if (prevImm && !branchTaken) begin
         selSimm = {bufInst.imm, selWord.imm};
      end else begin
         selSimm = {{16{selWord.imm[15]}}, selWord.imm};
      end
   end

   // Pipeline register
   always_ff @(posedge gclk) begin
      if (grst) begin
         bufInst <= '0;
         bufSimm <= '0;
      end else if (gena) begin
         bufInst <= selWord;
         bufSimm <= selSimm;
      end
   end

   // Two-cycle ops
   assign isMul      = fetchPkg::opcPair(selWord.opc, fetchPkg::opcMul);
   assign isBsf      = fetchPkg::opcPair(selWord.opc, fetchPkg::opcBsf);
   assign isLoad     = ({selWord.opc[5:4], selWord.opc[2]} == 3'b110);
   assign isStore    = ({selWord.opc[5:4], selWord.opc[2]} == 3'b111);
   assign multiCycle = isMul | isBsf | isLoad | isStore;

   // Stall toggle
   // High for one cycle and dropped at once when operands complete
   always_ff @(posedge gclk) begin
      if (grst) begin
         stall <= 1'b0;
      end else if (!oena) begin
         stall <= !stall & multiCycle;
      end else begin
         stall <= 1'b0;
      end
   end

endmodule

// File: verilog/instDecode.sv
// Registered decoder; only classifies and splits fields, register reads happen downstream
`timescale 1ns/1ps

module instDecode (
   input  logic                 gclk,
   input  logic                 grst,
   input  logic                 gena,
   input  fetchPkg::instWord    bufInst,
   input  logic [31:0]          bufSimm,
   output fetchPkg::decodedInst decOut
);

   fetchPkg::opClass cls;
   logic [4:0]       rb;
   logic [10:0]      alt;

   // Type A view of the immediate field
   assign rb  = bufInst.imm[15:11];
   assign alt = bufInst.imm[10:0];

   // Class lookup
   // Exact filler word checked first since it shares an ALU opcode
   always_comb begin
      if (bufInst == fetchPkg::nopWord) begin
         cls = fetchPkg::opNop;
      end else if (bufInst.opc == fetchPkg::opcImm) begin
         cls = fetchPkg::opImmPrefix;
      end else if (bufInst.opc == fetchPkg::opcRtd) begin
         cls = fetchPkg::opReturn;
      end else if (fetchPkg::opcPair(bufInst.opc, fetchPkg::opcBru)) begin
         cls = fetchPkg::opBranch;
      end else if (fetchPkg::opcPair(bufInst.opc, fetchPkg::opcBcc)) begin
         cls = fetchPkg::opCondBranch;
      end else if (fetchPkg::opcPair(bufInst.opc, fetchPkg::opcMul)) begin
         cls = fetchPkg::opMul;
      end else if (fetchPkg::opcPair(bufInst.opc, fetchPkg::opcBsf)) begin
         cls = fetchPkg::opShift;
      end else if ({bufInst.opc[5:4], bufInst.opc[2]} == 3'b110) begin
         cls = fetchPkg::opLoad;
      end else if ({bufInst.opc[5:4], bufInst.opc[2]} == 3'b111) begin
         cls = fetchPkg::opStore;
      end else begin
         cls = fetchPkg::opAlu;
      end
   end

   // Decode register
   // Zero reset reads back as opAlu
   always_ff @(posedge gclk) begin
      if (grst) begin
         decOut <= '0;
      end else if (gena) begin
         decOut.cls  <= cls;
         decOut.rd   <= bufInst.rd;
         decOut.ra   <= bufInst.ra;
         decOut.rb   <= rb;
         decOut.alt  <= alt;
         decOut.simm <= bufSimm;
      end
   end

endmodule

// File: vlog.f
+incdir+sim
verilog/fetchPkg.sv
verilog/fetchCounter.sv
verilog/instBuffer.sv
verilog/instDecode.sv
verilog/fetchFront.sv
sim/fetchFrontTb.sv
